//--- design/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// address and data path width of the core
`define XLEN 32

// first fetch address after reset or flush, must be word aligned
`define RESET_PC 32'h0000_0000

// what an unsupported compressed encoding turns into
// the all-zero word is illegal in the base ISA as well
`define ILLEGAL_INST 32'h0000_0000

`endif

//--- design/rv_isa_pkg.sv
package rv_isa_pkg;

    typedef logic [15:0] half_t;    // one parcel, a compressed instruction fits here
    typedef logic [31:0] inst_t;    // full base instruction

    // major opcodes the compressed forms map onto
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // low two bits of a halfword
    // anything but QUAD_FULL is a 16-bit instruction
    typedef enum logic [1:0] {
        QUAD_0    = 2'b00,
        QUAD_1    = 2'b01,
        QUAD_2    = 2'b10,
        QUAD_FULL = 2'b11
    } quadrant_e;

endpackage

//--- design/fetch_pkg.sv
`include "fetch_params.svh"

package fetch_pkg;

    // one instruction handed to decode
    typedef struct packed {
        logic              valid;
        rv_isa_pkg::inst_t inst;       // always the 32-bit form
        logic [`XLEN-1:0]  pc;
        logic [`XLEN-1:0]  next_pc;    // pc + 2 or pc + 4
    } fetch_out_t;

    // restart request from execute
    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] target;
    } redirect_t;

    // what the halfword buffer currently holds
    typedef enum logic [1:0] {
        EMPTY    = 2'd0,    // start from the low half of the presented word
        HELD     = 2'd1,    // compressed upper half waiting to be sent
        STRADDLE = 2'd2     // lower half of a 32-bit instruction, rest in next word
    } align_state_e;

endpackage

//--- design/rvc_expander.sv
`include "fetch_params.svh"

module rvc_expander (
    input  rv_isa_pkg::half_t half_i,
    output rv_isa_pkg::inst_t inst_o
);
    import rv_isa_pkg::*;

    logic [4:0]  rd;          // full register fields
    logic [4:0]  rs2;
    logic [4:0]  rp_lo;       // x8..x15 taken from bits 4:2
    logic [4:0]  rp_hi;       // x8..x15 taken from bits 9:7
    logic [11:0] imm6;        // sign extended 6-bit immediate
    logic [19:0] jal_imm;     // c.j/c.jal offset already in J-type order
    logic [6:0]  ca_funct7;
    logic [2:0]  ca_funct3;

    assign rd      = half_i[11:7];
    assign rs2     = half_i[6:2];
    assign rp_lo   = {2'b01, half_i[4:2]};
    assign rp_hi   = {2'b01, half_i[9:7]};
    assign imm6    = {{7{half_i[12]}}, half_i[6:2]};
    assign jal_imm = {half_i[12], half_i[8], half_i[10:9], half_i[6], half_i[7],
                      half_i[2], half_i[11], half_i[5:3], {9{half_i[12]}}};

    // sub / xor / or / and picked by bits 6:5
    assign ca_funct7 = (half_i[6:5] == 2'b00) ? 7'b0100000 : 7'b0000000;
    assign ca_funct3 = (half_i[6:5] == 2'b00) ? 3'b000 : {1'b1, half_i[6], &half_i[6:5]};

    always_comb begin
        inst_o = `ILLEGAL_INST;
        case ({half_i[1:0], half_i[15:13]})
            {QUAD_0, 3'b000}: begin  // c.addi4spn, zero immediate is reserved
                if (half_i[12:5] != 8'd0) begin
                    inst_o = {2'b00, half_i[10:7], half_i[12:11], half_i[5], half_i[6],
                              2'b00, 5'd2, 3'b000, rp_lo, OPC_OP_IMM};
                end
            end
            {QUAD_0, 3'b010}: begin  // c.lw
                inst_o = {5'd0, half_i[5], half_i[12:10], half_i[6], 2'b00,
                          rp_hi, 3'b010, rp_lo, OPC_LOAD};
            end
            {QUAD_0, 3'b110}: begin  // c.sw
                inst_o = {5'd0, half_i[5], half_i[12], rp_lo, rp_hi, 3'b010,
                          half_i[11:10], half_i[6], 2'b00, OPC_STORE};
            end
            {QUAD_1, 3'b000}: inst_o = {imm6, rd, 3'b000, rd, OPC_OP_IMM};    // c.addi, c.nop
            {QUAD_1, 3'b001}: inst_o = {jal_imm, 5'd1, OPC_JAL};              // c.jal
            {QUAD_1, 3'b010}: inst_o = {imm6, 5'd0, 3'b000, rd, OPC_OP_IMM};  // c.li
            {QUAD_1, 3'b011}: begin
                if (rd == 5'd2) begin  // c.addi16sp
                    inst_o = {{3{half_i[12]}}, half_i[4:3], half_i[5], half_i[2], half_i[6],
                              4'b0000, 5'd2, 3'b000, 5'd2, OPC_OP_IMM};
                end else begin  // c.lui
                    inst_o = {{15{half_i[12]}}, half_i[6:2], rd, OPC_LUI};
                end
            end
            {QUAD_1, 3'b100}: begin
                case (half_i[11:10])
                    2'b10: inst_o = {imm6, rp_hi, 3'b111, rp_hi, OPC_OP_IMM};  // c.andi
                    2'b11: begin
                        // bit 12 set selects the RV64 word ops
                        if (!half_i[12]) begin
                            inst_o = {ca_funct7, rp_lo, rp_hi, ca_funct3, rp_hi, OPC_OP};
                        end
                    end
                    default: begin  // c.srli and c.srai, bit 10 picks arithmetic
                        if (!half_i[12]) begin
                            inst_o = {1'b0, half_i[10], 5'd0, rs2, rp_hi, 3'b101,
                                      rp_hi, OPC_OP_IMM};
                        end
                    end
                endcase
            end
            {QUAD_1, 3'b101}: inst_o = {jal_imm, 5'd0, OPC_JAL};  // c.j
            {QUAD_1, 3'b110},
            {QUAD_1, 3'b111}: begin  // c.beqz / c.bnez, bit 13 becomes funct3[0]
                inst_o = {{4{half_i[12]}}, half_i[6:5], half_i[2], 5'd0, rp_hi, 2'b00,
                          half_i[13], half_i[11:10], half_i[4:3], half_i[12], OPC_BRANCH};
            end
            {QUAD_2, 3'b000}: begin  // c.slli, shamt[5] must be clear on RV32
                if (!half_i[12]) begin
                    inst_o = {7'd0, rs2, rd, 3'b001, rd, OPC_OP_IMM};
                end
            end
            {QUAD_2, 3'b010}: begin  // c.lwsp
                inst_o = {4'd0, half_i[3:2], half_i[12], half_i[6:4], 2'b00,
                          5'd2, 3'b010, rd, OPC_LOAD};
            end
            {QUAD_2, 3'b100}: begin
                if (!half_i[12]) begin
                    if (rs2 != 5'd0) begin
                        inst_o = {7'd0, rs2, 5'd0, 3'b000, rd, OPC_OP};      // c.mv
                    end else if (rd != 5'd0) begin
                        inst_o = {12'd0, rd, 3'b000, 5'd0, OPC_JALR};        // c.jr
                    end
                end else if (rs2 != 5'd0) begin
                    inst_o = {7'd0, rs2, rd, 3'b000, rd, OPC_OP};            // c.add
                end else if (rd != 5'd0) begin
                    inst_o = {12'd0, rd, 3'b000, 5'd1, OPC_JALR};            // c.jalr
                end else begin
                    inst_o = {12'd1, 5'd0, 3'b000, 5'd0, OPC_SYSTEM};        // c.ebreak
                end
            end
            {QUAD_2, 3'b110}: begin  // c.swsp
                inst_o = {4'd0, half_i[8:7], half_i[12], rs2, 5'd2, 3'b010,
                          half_i[11:9], 2'b00, OPC_STORE};
            end
            default: inst_o = `ILLEGAL_INST;
        endcase
    end

endmodule

//--- design/fetch_aligner.sv
`include "fetch_params.svh"

module fetch_aligner (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  stall_i,
    input  logic                  flush_i,
    input  logic                  imem_wait_i,
    input  rv_isa_pkg::inst_t     imem_data_i,
    input  fetch_pkg::redirect_t  redirect_i,
    output logic                  advance_o,
    output fetch_pkg::fetch_out_t fetch_o
);
    import rv_isa_pkg::*;
    import fetch_pkg::*;

    align_state_e     state_q;
    align_state_e     state_d;
    half_t            half_q;       // upper halfword of the last accepted word
    logic [`XLEN-1:0] pc_q;         // pc of the next instruction to emit
    half_t            rvc_half;
    inst_t            rvc_inst;
    fetch_out_t       out_d;
    logic             emit_rvc;
    logic             hi_full;      // upper half opens a 32-bit instruction
    logic             valid_q;
    inst_t            inst_q;
    logic [`XLEN-1:0] out_pc_q;
    logic [`XLEN-1:0] out_next_q;

    assign hi_full  = (imem_data_i[17:16] == QUAD_FULL);
    assign rvc_half = (state_q == HELD) ? half_q : imem_data_i[15:0];

    rvc_expander i_rvc_expander (
        .half_i (rvc_half),
        .inst_o (rvc_inst)
    );

    always_comb begin
        state_d     = EMPTY;
        advance_o   = 1'b1;
        emit_rvc    = 1'b0;
        out_d.valid = 1'b1;
        out_d.inst  = imem_data_i;              // aligned 32-bit word by default
        case (state_q)
            EMPTY: begin
                if (imem_data_i[1:0] != QUAD_FULL) begin
                    // compressed low half, the word stays for its upper half
                    emit_rvc   = 1'b1;
                    out_d.inst = rvc_inst;
                    state_d    = hi_full ? STRADDLE : HELD;
                    advance_o  = hi_full;
                end
            end
            HELD: begin                         // compressed upper half from the buffer
                emit_rvc   = 1'b1;
                out_d.inst = rvc_inst;
            end
            STRADDLE: begin
                out_d.inst = {imem_data_i[15:0], half_q};  // join across the word boundary
                state_d    = hi_full ? STRADDLE : HELD;
                advance_o  = hi_full;
            end
            default: out_d.valid = 1'b0;
        endcase
        out_d.pc      = pc_q;
        out_d.next_pc = pc_q + (emit_rvc ? 2 : 4);
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            state_q <= EMPTY;
            pc_q    <= `RESET_PC;
            valid_q <= 1'b0;
        end else if (redirect_i.valid) begin
            state_q <= EMPTY;                   // anything buffered is dropped
            pc_q    <= redirect_i.target;
            valid_q <= 1'b0;
        end else if (!stall_i) begin
            if (!imem_wait_i) begin
                state_q <= state_d;
                pc_q    <= out_d.next_pc;
            end
            valid_q <= out_d.valid & ~imem_wait_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i && !imem_wait_i) begin
            half_q     <= imem_data_i[31:16];
            inst_q     <= out_d.inst;
            out_pc_q   <= out_d.pc;
            out_next_q <= out_d.next_pc;
        end
    end

    assign fetch_o = '{valid: valid_q, inst: inst_q, pc: out_pc_q, next_pc: out_next_q};

    // nothing from the old path may reach decode once execute has redirected
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        redirect_i.valid |=> !fetch_o.valid);

endmodule

//--- design/fetch_pc_gen.sv
`include "fetch_params.svh"

module fetch_pc_gen (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 stall_i,
    input  logic                 flush_i,
    input  logic                 imem_wait_i,
    input  logic                 advance_i,
    input  fetch_pkg::redirect_t redirect_i,
    output logic [`XLEN-1:0]     imem_addr_o,
    output logic                 mispredict_o
);

    // word address register, the aligner decides when to move on
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            imem_addr_o  <= `RESET_PC;
            mispredict_o <= 1'b0;
        end else begin
            mispredict_o <= redirect_i.valid;   // pulse follows the redirect strobe
            if (redirect_i.valid) begin
                imem_addr_o <= redirect_i.target;   // wins over stall
            end else if (advance_i && !imem_wait_i && !stall_i) begin
                imem_addr_o <= imem_addr_o + 4;
            end
        end
    end

    // the aligner always restarts on a low half
    // so execute may only send word aligned targets
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        redirect_i.valid |-> (redirect_i.target[1:0] == 2'b00));

endmodule

//--- design/fetch_stage.sv
`include "fetch_params.svh"

module fetch_stage (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  stall_i,
    input  logic                  flush_i,
    input  logic                  imem_wait_i,
    input  rv_isa_pkg::inst_t     imem_data_i,
    input  fetch_pkg::redirect_t  redirect_i,
    output logic [`XLEN-1:0]      imem_addr_o,
    output fetch_pkg::fetch_out_t fetch_o,
    output logic                  mispredict_o
);

    logic advance;  // aligner is done with the presented word

    fetch_pc_gen i_fetch_pc_gen (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .imem_wait_i  (imem_wait_i),
        .advance_i    (advance),
        .redirect_i   (redirect_i),
        .imem_addr_o  (imem_addr_o),
        .mispredict_o (mispredict_o)
    );

    fetch_aligner i_fetch_aligner (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .stall_i     (stall_i),
        .flush_i     (flush_i),
        .imem_wait_i (imem_wait_i),
        .imem_data_i (imem_data_i),
        .redirect_i  (redirect_i),
        .advance_o   (advance),
        .fetch_o     (fetch_o)
    );

endmodule

//--- testbench/fetch_stage_tb_table.svh
`ifndef FETCH_STAGE_TB_TABLE_SVH
`define FETCH_STAGE_TB_TABLE_SVH

// program image, one 32-bit word per entry starting at address 0
localparam int IMAGE_WORDS = 24;
localparam logic [31:0] IMAGE [0:IMAGE_WORDS-1] = '{
    32'h00500093, 32'h002081b3, 32'h04050001, 32'h6285557d,    // aligned words, nop addi li lui
    32'h888d6141, 32'h52378111, 32'h85891234, 32'h8c258c05,    // straddle at 0x16
    32'h8c658c45, 32'h83a2030e, 32'h808293a2, 32'h90029282,
    32'hc6364622, 32'hc5044144, 32'h24230040, 32'h00930095,    // two straddles in a row
    32'ha0210050, 32'hc4012021, 32'h8000e401, 32'h002081b3,    // 0x8000 is reserved
    32'h00100073, 32'h00100073, 32'h0405557d, 32'h00500093     // 0x50..0x57 is skipped
};

// columns are kind, pc (redirect target for a redirect row), instruction, next pc
localparam int NUM_ROWS = 43;
localparam row_t ROWS [0:NUM_ROWS-1] = '{
    '{K_INST, 32'h00, 32'h00500093, 32'h04}, '{K_INST, 32'h04, 32'h002081b3, 32'h08},
    '{K_INST, 32'h08, 32'h00000013, 32'h0a}, '{K_INST, 32'h0a, 32'h00140413, 32'h0c},
    '{K_INST, 32'h0c, 32'hfff00513, 32'h0e}, '{K_INST, 32'h0e, 32'h000012b7, 32'h10},
    '{K_INST, 32'h10, 32'h01010113, 32'h12}, '{K_INST, 32'h12, 32'h0034f493, 32'h14},
    '{K_INST, 32'h14, 32'h00455513, 32'h16}, '{K_INST, 32'h16, 32'h12345237, 32'h1a},
    '{K_INST, 32'h1a, 32'h4025d593, 32'h1c}, '{K_INST, 32'h1c, 32'h40940433, 32'h1e},
    '{K_INST, 32'h1e, 32'h00944433, 32'h20}, '{K_INST, 32'h20, 32'h00946433, 32'h22},
    '{K_INST, 32'h22, 32'h00947433, 32'h24}, '{K_INST, 32'h24, 32'h00331313, 32'h26},
    '{K_INST, 32'h26, 32'h008003b3, 32'h28}, '{K_INST, 32'h28, 32'h008383b3, 32'h2a},
    '{K_INST, 32'h2a, 32'h00008067, 32'h2c}, '{K_INST, 32'h2c, 32'h000280e7, 32'h2e},
    '{K_INST, 32'h2e, 32'h00100073, 32'h30}, '{K_INST, 32'h30, 32'h00812603, 32'h32},
    '{K_INST, 32'h32, 32'h00d12623, 32'h34}, '{K_INST, 32'h34, 32'h00452483, 32'h36},
    '{K_INST, 32'h36, 32'h00952423, 32'h38}, '{K_INST, 32'h38, 32'h00410413, 32'h3a},
    '{K_INST, 32'h3a, 32'h00952423, 32'h3e}, '{K_INST, 32'h3e, 32'h00500093, 32'h42},
    '{K_INST, 32'h42, 32'h0080006f, 32'h44}, '{K_INST, 32'h44, 32'h008000ef, 32'h46},
    '{K_INST, 32'h46, 32'h00040463, 32'h48}, '{K_INST, 32'h48, 32'h00041463, 32'h4a},
    '{K_INST, 32'h4a, 32'h00000000, 32'h4c}, '{K_INST, 32'h4c, 32'h002081b3, 32'h50},
    '{K_REDIR, 32'h58, 32'h00000000, 32'h00}, '{K_INST, 32'h58, 32'hfff00513, 32'h5a},
    '{K_INST, 32'h5a, 32'h00140413, 32'h5c}, '{K_INST, 32'h5c, 32'h00500093, 32'h60},
    '{K_FLUSH, 32'h00, 32'h00000000, 32'h00}, '{K_INST, 32'h00, 32'h00500093, 32'h04},
    '{K_INST, 32'h04, 32'h002081b3, 32'h08}, '{K_INST, 32'h08, 32'h00000013, 32'h0a},
    '{K_INST, 32'h0a, 32'h00140413, 32'h0c}
};

`endif

//--- testbench/fetch_stage_tb.sv
`include "fetch_params.svh"

module fetch_stage_tb;
    import rv_isa_pkg::*;
    import fetch_pkg::*;

    typedef struct packed {
        logic [1:0]  kind;
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] next_pc;
    } row_t;

    localparam logic [1:0] K_INST  = 2'd0;    // one consumed instruction
    localparam logic [1:0] K_REDIR = 2'd1;    // redirect from execute
    localparam logic [1:0] K_FLUSH = 2'd2;

    `include "fetch_stage_tb_table.svh"

    localparam int TIMEOUT_CYCLES = 4 * NUM_ROWS + 50;

    logic        clk;
    logic        rst_n;
    logic        stall;
    logic        flush;
    logic        imem_wait;
    inst_t       imem_data;
    redirect_t   redirect;
    logic [31:0] imem_addr;
    fetch_out_t  fetch;
    logic        mispredict;
    integer      seed = 32'h6798_7de6;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    bit          consumed;

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // memory answers in the same cycle
    always_comb begin
        if (imem_addr < 32'(4 * IMAGE_WORDS)) begin
            imem_data = IMAGE[imem_addr[6:2]];
        end else begin
            imem_data = imem_addr ^ 32'h5a5a_0f0f;    // address pattern outside the image
        end
    end

    fetch_stage i_fetch_stage (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .stall_i      (stall),
        .flush_i      (flush),
        .imem_wait_i  (imem_wait),
        .imem_data_i  (imem_data),
        .redirect_i   (redirect),
        .imem_addr_o  (imem_addr),
        .fetch_o      (fetch),
        .mispredict_o (mispredict)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic draw_stall_wait();
        stall     <= ($random(seed) & 3) == 0;    // about one cycle in four
        imem_wait <= ($random(seed) & 3) == 0;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout, the instruction stream did not finish in %0d cycles", cycles);
            $display("checks %0d errors %0d", checks, errors);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        rst_n     = 1'b0;
        stall     = 1'b0;
        flush     = 1'b0;
        imem_wait = 1'b0;
        redirect  = '0;
        repeat (4) @(posedge clk);
        check_value("fetch_o.valid", fetch.valid, 0);
        check_value("mispredict_o", mispredict, 0);
        check_value("imem_addr_o", imem_addr, `RESET_PC);
        rst_n <= 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            case (ROWS[i].kind)
                K_INST: begin
                    consumed = 1'b0;
                    while (!consumed) begin
                        @(posedge clk);
                        check_value("mispredict_o", mispredict, 0);    // no pulse here
                        if (fetch.valid && !stall) begin    // taken at this edge
                            consumed = 1'b1;
                            check_value("fetch_o.pc", fetch.pc, ROWS[i].pc);
                            check_value("fetch_o.inst", fetch.inst, ROWS[i].inst);
                            check_value("fetch_o.next_pc", fetch.next_pc, ROWS[i].next_pc);
                        end
                        draw_stall_wait();
                    end
                end
                K_REDIR: begin
                    // the younger instruction on fetch_o is killed by execute
                    redirect <= '{valid: 1'b1, target: ROWS[i].pc};
                    @(posedge clk);
                    redirect <= '0;
                    draw_stall_wait();
                    @(posedge clk);
                    check_value("mispredict_o", mispredict, 1);
                    check_value("fetch_o.valid", fetch.valid, 0);
                    draw_stall_wait();
                end
                default: begin
                    flush <= 1'b1;
                    @(posedge clk);
                    flush <= 1'b0;
                    draw_stall_wait();
                    @(posedge clk);
                    check_value("imem_addr_o", imem_addr, `RESET_PC);
                    check_value("fetch_o.valid", fetch.valid, 0);
                    check_value("mispredict_o", mispredict, 0);
                    draw_stall_wait();
                end
            endcase
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- fetch_stage.f
+incdir+design
+incdir+testbench
design/rv_isa_pkg.sv
design/fetch_pkg.sv
design/rvc_expander.sv
design/fetch_aligner.sv
design/fetch_pc_gen.sv
design/fetch_stage.sv
testbench/fetch_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module fetch_stage_tb \
    -f fetch_stage.f -o fetch_stage_sim

output=$(./obj_dir/fetch_stage_sim)
echo "$output"
echo "$output" | grep -q "^NO ERRORS$"
